// ==== sim.f ====
hw/serdes_rx_pkg.sv
hw/bit_deserializer.sv
hw/phase_align_monitor.sv
hw/rx_word_capture.sv
hw/serdes_rx_top.sv
test/serdes_rx_properties.sv
test/serdes_rx_checker.sv
test/serdes_rx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the serial receive testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module serdes_rx_tb -o serdes_rx_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

# Keep running past assertion errors so the testbench prints its summary
OUTPUT=$(./obj_dir/serdes_rx_sim +verilator+error+limit+1000 2>&1)
STATUS=$?
printf '%s\n' "$OUTPUT"
if [ $STATUS -ne 0 ]; then
    echo "Simulation exited with status $STATUS"
    exit 1
fi

if printf '%s\n' "$OUTPUT" | grep -q "All tests passed!"; then
    exit 0
fi
exit 1

// ==== test/serdes_rx_tb.sv ====
/*
 * Receive-path testbench, serial bits driven MSB-first on the rising edge
 * Idle fill is all-zero words, so only the table's training words can lock
 * Rows that expect lock must hold s equal to k
 */
`timescale 1ns/1ps
`default_nettype none

module serdes_rx_tb;
    import serdes_rx_pkg::*;

    localparam int NUM_ROWS    = 10;
    localparam int SEED        = 47;
    localparam int FILL_MARGIN = 4;                     // Fill past the settle wait
    localparam logic [WORD_WIDTH-1:0] IDLE_WORD = '0;   // Never matches training

    typedef struct packed {
        int k;        // Junk bits ahead of the stream
        int s;        // Slip cycles at the start
        bit en;       // enable_n held low
        int n_train;  // Training words
        int n_pay;    // Random payload words
        bit lock;     // Table's lock expectation
    } row_t;

    logic                  fabric_clk_div;
    logic                  reset_buf_n;
    logic                  enable_n;
    logic                  data_i;
    logic                  bitslip_ctrl_n;
    logic [WORD_WIDTH-1:0] data_o;
    logic                  ready;
    int                    chk_errors;
    int                    prop_fails;
    int                    since_rst = 0;     // Rising edges since reset release
    int                    cycles = 0;
    int                    cycle_limit = 0;   // Zero until the table is loaded
    row_t                  rows [NUM_ROWS];
    string                 row_names [NUM_ROWS];

    serdes_rx_top uut (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .enable_n       (enable_n),
        .data_i         (data_i),
        .bitslip_ctrl_n (bitslip_ctrl_n),
        .data_o         (data_o),
        .ready          (ready)
    );

    serdes_rx_checker chk (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .data_o         (data_o),
        .ready          (ready),
        .error_count    (chk_errors)
    );

    bind serdes_rx_top serdes_rx_properties u_props (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .word_valid     (word_valid),   // Internal strobe of the top level
        .ready          (ready),
        .data_o         (data_o)
    );

    assign prop_fails = uut.u_props.assert_fails;

    initial begin
        fabric_clk_div = 1'b0;
        forever #4 fabric_clk_div = ~fabric_clk_div;   // 8 ns period
    end

    // Run limit from the table's length
    always @(posedge fabric_clk_div) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("Test failures found");
            $finish;
        end
    end

    // ****************************************
    // Scenario table
    // ****************************************
    task automatic add_row(input int idx, input string name, input int k, input int s,
                           input bit en, input int n_train, input int n_pay, input bit lock);
        row_names[idx] = name;
        rows[idx]      = '{k, s, en, n_train, n_pay, lock};
    endtask

    task automatic load_table();
        add_row(0, "aligned",        0, 0, 1'b1, 8, 8,  1'b1);
        add_row(1, "offset1_noslip", 1, 0, 1'b1, 8, 4,  1'b0);
        add_row(2, "offset2_noslip", 2, 0, 1'b1, 8, 4,  1'b0);
        add_row(3, "offset3_noslip", 3, 0, 1'b1, 8, 4,  1'b0);
        add_row(4, "offset1_slip",   1, 1, 1'b1, 8, 8,  1'b1);
        add_row(5, "offset2_slip",   2, 2, 1'b1, 8, 8,  1'b1);
        add_row(6, "offset3_slip",   3, 3, 1'b1, 8, 8,  1'b1);
        add_row(7, "disabled",       0, 0, 1'b0, 8, 4,  1'b0);
        add_row(8, "short_training", 0, 0, 1'b1, 2, 4,  1'b0);
        add_row(9, "back_to_back",   2, 2, 1'b1, 8, 32, 1'b1);
    endtask

    function automatic int run_budget();
        int total;
        total = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            total += LOCK_WAIT + (rows[i].n_train + rows[i].n_pay + 4) * WORD_WIDTH + 20;
        end
        return total;
    endfunction

    // ****************************************
    // Stream driver
    // ****************************************
    task automatic apply_reset();
        repeat (5) begin
            @(posedge fabric_clk_div);
            reset_buf_n    <= 1'b0;
            bitslip_ctrl_n <= 1'b0;   // Cycle after release gets dropped
            data_i         <= 1'b0;
        end
    endtask

    task automatic drive_bit(input logic b, input logic keep);
        @(posedge fabric_clk_div);
        data_i         <= b;
        bitslip_ctrl_n <= keep;       // Low slips this bit
        since_rst      = since_rst + 1;
    endtask

    task automatic drive_word(input logic [WORD_WIDTH-1:0] w);
        for (int i = WORD_WIDTH - 1; i >= 0; i--) begin
            drive_bit(w[i], 1'b1);    // MSB first
        end
    endtask

    task automatic run_scenario(input int idx);
        row_t                  r;
        logic [WORD_WIDTH-1:0] w;
        r = rows[idx];
        apply_reset();
        chk.begin_scenario(row_names[idx], r.k, r.s, r.en, r.n_train, r.lock);
        @(posedge fabric_clk_div);
        reset_buf_n <= 1'b1;
        enable_n    <= ~r.en;
        since_rst   = 0;
        for (int j = 0; j < r.k; j++) begin
            drive_bit(1'($urandom()), (j < r.s) ? 1'b0 : 1'b1);   // Junk, slipped or kept
        end
        for (int t = 0; t < r.n_train; t++) begin
            drive_word(TRAIN_PATTERN);
        end
        while (since_rst < LOCK_WAIT + FILL_MARGIN) begin
            drive_word(IDLE_WORD);
        end
        for (int p = 0; p < r.n_pay; p++) begin
            w = WORD_WIDTH'($urandom());
            drive_word(w);
            chk.expect_word(w);       // Last bit just driven
        end
        drive_word(IDLE_WORD);        // Flush the last payload word
        @(negedge fabric_clk_div);
        chk.end_scenario();
    endtask

    initial begin
        void'($urandom(SEED));
        reset_buf_n    = 1'b0;
        enable_n       = 1'b1;
        data_i         = 1'b0;
        bitslip_ctrl_n = 1'b0;
        load_table();
        cycle_limit = run_budget();
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_scenario(i);
        end
        @(posedge fabric_clk_div);
        $display("Run complete: %0d checker errors, %0d assertion failures",
                 chk_errors, prop_fails);
        if (chk_errors == 0 && prop_fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/serdes_rx_checker.sv ====
/*
 * Compares DUT ports with values predicted from the link rules
 * Outputs are sampled on the falling edge, away from the driving edge
 * A payload word is due on data_o 2 cycles after its last bit
 */
`timescale 1ns/1ps
`default_nettype none

module serdes_rx_checker (
    input  wire                                 fabric_clk_div,  // Bit clock
    input  wire                                 reset_buf_n,     // Async, active low
    input  wire [serdes_rx_pkg::WORD_WIDTH-1:0] data_o,          // DUT word out
    input  wire                                 ready,           // DUT ready
    output int                                  error_count      // Checker errors
);
    import serdes_rx_pkg::*;

    logic [WORD_WIDTH-1:0] exp_words [$];   // Payload still to appear
    int                    exp_due [$];     // Falling edge each one is due
    int                    neg_cnt = 0;
    int                    rst_cnt = 0;     // Falling edges since reset release
    bit                    active = 1'b0;
    bit                    lock_exp = 1'b0;
    string                 scen = "";

    initial error_count = 0;

    task automatic value_fail(input string what, input logic [WORD_WIDTH-1:0] exp,
                              input logic [WORD_WIDTH-1:0] act);
        error_count++;
        $display("[FAIL] %s: %s expected %h, actual %h", scen, what, exp, act);
    endtask

    // ****************************************
    // Scenario control from the testbench
    // ****************************************
    task automatic begin_scenario(input string name, input int k, input int s,
                                  input bit en, input int n_train, input bit table_lock);
        scen     = name;
        lock_exp = en && (s == k) && (n_train >= LOCK_MATCHES);   // Aligned and trained
        if (lock_exp != table_lock) begin
            error_count++;
            $display("ERROR %s: table expects lock %0d but the link rules give %0d",
                     scen, table_lock, lock_exp);
        end
        if (ready !== 1'b0) value_fail("ready after reset", '0, WORD_WIDTH'(ready));
        if (data_o !== '0) value_fail("data_o after reset", '0, data_o);
        exp_words.delete();
        exp_due.delete();
        active = 1'b1;
    endtask

    task automatic expect_word(input logic [WORD_WIDTH-1:0] w);
        if (lock_exp) begin
            exp_words.push_back(w);
            exp_due.push_back(neg_cnt + 3);   // Sampled, strobed, then loaded
        end
    endtask

    task automatic end_scenario();
        if (lock_exp && ready !== 1'b1) value_fail("ready at end", WORD_WIDTH'(1),
                                                   WORD_WIDTH'(ready));
        if (exp_words.size() != 0) begin
            error_count++;
            $display("ERROR %s: %0d payload words never reached data_o",
                     scen, exp_words.size());
        end
        active = 1'b0;
    endtask

    always @(negedge fabric_clk_div) begin
        neg_cnt = neg_cnt + 1;
        if (!reset_buf_n) begin
            rst_cnt = 0;
        end else if (rst_cnt <= LOCK_WAIT + 1) begin
            rst_cnt = rst_cnt + 1;               // Saturates past the wait
        end
        if (active && reset_buf_n) begin
            if (ready && rst_cnt <= LOCK_WAIT + 1) begin
                error_count++;
                $display("ERROR %s: ready went high only %0d cycles after reset",
                         scen, rst_cnt);
            end
            if (!lock_exp && ready !== 1'b0) value_fail("ready", '0, WORD_WIDTH'(ready));
            if (!lock_exp && data_o !== '0) value_fail("data_o", '0, data_o);
            while (exp_due.size() != 0 && exp_due[0] == neg_cnt) begin
                if (data_o !== exp_words[0]) value_fail("data_o", exp_words[0], data_o);
                void'(exp_words.pop_front());
                void'(exp_due.pop_front());
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/serdes_rx_properties.sv ====
/*
 * Concurrent checks on the receive top level, attached with bind
 * Each failing assertion also bumps assert_fails for the final count
 */
`timescale 1ns/1ps
`default_nettype none

module serdes_rx_properties (
    input wire                                 fabric_clk_div,  // Bit clock
    input wire                                 reset_buf_n,     // Async, active low
    input wire                                 word_valid,      // Deserializer strobe
    input wire                                 ready,
    input wire [serdes_rx_pkg::WORD_WIDTH-1:0] data_o
);
    import serdes_rx_pkg::*;

    int assert_fails = 0;
    int settle_cnt = 0;   // Cycles since reset release, saturating

    always @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            settle_cnt <= 0;
        end else if (settle_cnt <= LOCK_WAIT) begin
            settle_cnt <= settle_cnt + 1;
        end
    end

    settle_before_ready: assert property (@(posedge fabric_clk_div) disable iff (!reset_buf_n)
        $rose(ready) |-> settle_cnt >= LOCK_WAIT)
        else begin
            assert_fails++;
            $error("ready rose before the settle wait ended");
        end

    capture_on_strobe: assert property (@(posedge fabric_clk_div) disable iff (!reset_buf_n)
        $changed(data_o) |-> $past(word_valid && ready))
        else begin
            assert_fails++;
            $error("data_o changed without a word strobe while ready");
        end

    ready_sticky: assert property (@(posedge fabric_clk_div)
        $fell(ready) |-> !reset_buf_n)       // Only reset drops ready
        else begin
            assert_fails++;
            $error("ready fell without a reset");
        end

endmodule

`default_nettype wire

// ==== hw/serdes_rx_top.sv ====
/*
 * Receive side of the serial link, bit clock is fabric_clk_div itself
 * Bitslip stays an external control; no automatic boundary search
 * Latency from last bit at data_i to data_o is 2 cycles while ready
 */
`timescale 1ns/1ps
`default_nettype none

module serdes_rx_top (
    input  wire                                  fabric_clk_div,  // Bit clock
    input  wire                                  reset_buf_n,     // Async, active low
    input  wire                                  enable_n,        // Active-low enable
    input  wire                                  data_i,          // Serial data
    input  wire                                  bitslip_ctrl_n,  // Active-low slip
    output logic [serdes_rx_pkg::WORD_WIDTH-1:0] data_o,          // Aligned word out
    output logic                                 ready            // Wait done and locked
);
    import serdes_rx_pkg::*;

    logic [WORD_WIDTH-1:0] word;        // Deserializer to monitor and capture
    logic                  word_valid;
    logic                  dpa_lock;    // Monitor to capture

    bit_deserializer u_deser (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .enable_n       (enable_n),
        .data_i         (data_i),
        .bitslip_ctrl_n (bitslip_ctrl_n),
        .word           (word),
        .word_valid     (word_valid)
    );

    phase_align_monitor u_align (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .word           (word),
        .word_valid     (word_valid),
        .dpa_lock       (dpa_lock)
    );

    rx_word_capture u_capture (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .word           (word),
        .word_valid     (word_valid),
        .dpa_lock       (dpa_lock),
        .data_o         (data_o),
        .ready          (ready)
    );

endmodule

`default_nettype wire

// ==== hw/rx_word_capture.sv ====
/*
 * Power-up wait, ready generation and output word register
 * ready needs both the saturated wait count and dpa_lock, one cycle late
 * No back-pressure; words arriving while ready is low are dropped
 */
`timescale 1ns/1ps
`default_nettype none

module rx_word_capture (
    input  wire                                  fabric_clk_div,  // Bit clock
    input  wire                                  reset_buf_n,     // Async, active low
    input  wire  [serdes_rx_pkg::WORD_WIDTH-1:0] word,            // Deserialized word
    input  wire                                  word_valid,      // New word strobe
    input  wire                                  dpa_lock,        // From alignment monitor
    output logic [serdes_rx_pkg::WORD_WIDTH-1:0] data_o,          // Captured word
    output logic                                 ready            // Link usable
);
    import serdes_rx_pkg::*;

    logic [WAIT_CNT_W-1:0] wait_cnt;   // Cycles since reset release
    logic                  wait_done;

    assign wait_done = (wait_cnt == WAIT_CNT_W'(LOCK_WAIT));

    // ****************************************
    // Settle wait and ready
    // ****************************************
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            wait_cnt <= '0;
        end else if (!wait_done) begin
            wait_cnt <= wait_cnt + 1'b1;              // Saturates at LOCK_WAIT
        end
    end

    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            ready <= 1'b0;
        end else begin
            ready <= wait_done && dpa_lock;
        end
    end

    // Capture register, loads only while ready
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            data_o <= '0;
        end else if (word_valid && ready) begin
            data_o <= word;
        end
    end

endmodule

`default_nettype wire

// ==== hw/phase_align_monitor.sv ====
/*
 * Declares lock after LOCK_MATCHES consecutive TRAIN_PATTERN words
 * Lock is sticky until reset; no loss-of-lock detection
 * Only words flagged by word_valid are compared
 */
`timescale 1ns/1ps
`default_nettype none

module phase_align_monitor (
    input  wire                                  fabric_clk_div,  // Bit clock
    input  wire                                  reset_buf_n,     // Async, active low
    input  wire  [serdes_rx_pkg::WORD_WIDTH-1:0] word,            // Deserialized word
    input  wire                                  word_valid,      // New word strobe
    output logic                                 dpa_lock         // Registered lock flag
);
    import serdes_rx_pkg::*;

    align_state_e           state;
    align_state_e           state_nxt;
    logic [MATCH_CNT_W-1:0] match_cnt;      // Consecutive matches seen
    logic [MATCH_CNT_W-1:0] match_cnt_nxt;
    logic                   is_match;

    assign is_match = word_valid && (word == TRAIN_PATTERN);

    // ****************************************
    // Next-state logic
    // ****************************************
    always_comb begin
        state_nxt     = state;
        match_cnt_nxt = match_cnt;
        case (state)
            SEARCH: begin
                if (is_match) begin
                    match_cnt_nxt = MATCH_CNT_W'(1);  // First match counts
                    state_nxt     = (LOCK_MATCHES == 1) ? LOCKED : CHECK;
                end
            end
            CHECK: begin
                if (is_match) begin
                    match_cnt_nxt = match_cnt + 1'b1;
                    if (match_cnt_nxt == MATCH_CNT_W'(LOCK_MATCHES)) begin
                        state_nxt = LOCKED;
                    end
                end else if (word_valid) begin
                    match_cnt_nxt = '0;            // Run broken, start over
                    state_nxt     = SEARCH;
                end
            end
            LOCKED: begin
                state_nxt = LOCKED;                // Sticky
            end
            default: begin
                state_nxt     = SEARCH;
                match_cnt_nxt = '0;
            end
        endcase
    end

    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            state     <= SEARCH;
            match_cnt <= '0;
            dpa_lock  <= 1'b0;
        end else begin
            state     <= state_nxt;
            match_cnt <= match_cnt_nxt;
            dpa_lock  <= (state_nxt == LOCKED);    // Rises with LOCKED
        end
    end

endmodule

`default_nettype wire

// ==== hw/bit_deserializer.sv ====
/*
 * Serial-to-parallel shifter, one bit per fabric_clk_div cycle
 * Earliest kept bit lands in the MSB of word
 * Each cycle with bitslip_ctrl_n low drops its bit, moving the boundary one bit later
 * enable_n high forces zeros, which still count toward a word
 */
`timescale 1ns/1ps
`default_nettype none

module bit_deserializer (
    input  wire                                  fabric_clk_div,  // Bit clock
    input  wire                                  reset_buf_n,     // Async, active low
    input  wire                                  enable_n,        // Active-low input enable
    input  wire                                  data_i,          // Serial input bit
    input  wire                                  bitslip_ctrl_n,  // Low drops this bit
    output logic [serdes_rx_pkg::WORD_WIDTH-1:0] word,            // Last completed word
    output logic                                 word_valid       // One-cycle strobe
);
    import serdes_rx_pkg::*;

    logic                  bit_in;     // Gated serial bit
    logic                  keep_bit;   // Bit enters the shifter this cycle
    logic                  last_bit;   // Completes a word
    logic [WORD_WIDTH-1:0] word_next;  // Shifter contents plus incoming bit
    logic [WORD_WIDTH-2:0] shift_q;    // Bits of the word in progress
    logic [BIT_CNT_W-1:0]  bit_cnt;    // Kept bits so far in this word

    // ****************************************
    // Input gating
    // ****************************************
    assign bit_in    = enable_n ? 1'b0 : data_i;  // Disabled input reads as zero
    assign keep_bit  = bitslip_ctrl_n;            // Slip cycle discards the bit
    assign last_bit  = keep_bit && (bit_cnt == BIT_CNT_W'(WORD_WIDTH - 1));
    assign word_next = {shift_q, bit_in};         // MSB-first append

    // Shifter holds payload only
    always_ff @(posedge fabric_clk_div) begin
        if (keep_bit) begin
            shift_q <= word_next[WORD_WIDTH-2:0];
        end
    end

    // Kept-bit counter, frozen on slip
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            bit_cnt <= '0;                        // Next kept bit starts word 0
        end else if (keep_bit) begin
            bit_cnt <= last_bit ? '0 : bit_cnt + 1'b1;
        end
    end

    // ****************************************
    // Word output
    // ****************************************
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            word_valid <= 1'b0;
        end else begin
            word_valid <= last_bit;               // Cycle after the last bit
        end
    end

    always_ff @(posedge fabric_clk_div) begin
        if (last_bit) begin
            word <= word_next;                    // Held until the next word
        end
    end

endmodule

`default_nettype wire

// ==== hw/serdes_rx_pkg.sv ====
/*
 * Shared constants and types for the serial receive path
 * TRAIN_PATTERN must have no rotational symmetry or slipped words can match
 * Counter widths follow from the constants above them
 */
`default_nettype none

package serdes_rx_pkg;

    // ****************************************
    // Link constants
    // ****************************************
    localparam int WORD_WIDTH   = 4;                         // Bits per word
    localparam int LOCK_WAIT    = 255;                       // Settle wait after reset
    localparam int LOCK_MATCHES = 4;                         // Matches needed for lock

    localparam logic [WORD_WIDTH-1:0] TRAIN_PATTERN = 4'b1000;  // Single bit set

    // Derived widths
    localparam int BIT_CNT_W   = $clog2(WORD_WIDTH);         // Kept-bit counter
    localparam int WAIT_CNT_W  = $clog2(LOCK_WAIT + 1);      // Saturating wait counter
    localparam int MATCH_CNT_W = $clog2(LOCK_MATCHES + 1);   // Consecutive match counter

    // Alignment monitor states
    typedef enum logic [1:0] {
        SEARCH,  // Waiting for first training word
        CHECK,   // Counting consecutive matches
        LOCKED   // Sticky until reset
    } align_state_e;

endpackage

`default_nettype wire
